// ==== logic/isa_pkg.sv ====
package isa_pkg;

    localparam int XLEN      = 32;
    localparam int REG_IDX_W = 5;

    typedef logic [XLEN-1:0]      inst_t;
    typedef logic [XLEN-1:0]      word_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    // return address register for bl
    localparam reg_idx_t LINK_REG = 5'd1;

    // major opcode in inst[31:26]
    typedef enum logic [5:0] {
        OP_GRP0      = 6'h00,
        OP_LU12I     = 6'h05,
        OP_PCADDU12I = 6'h07,
        OP_MEM       = 6'h0a,
        OP_JIRL      = 6'h13,
        OP_B         = 6'h14,
        OP_BL        = 6'h15,
        OP_BEQ       = 6'h16,
        OP_BNE       = 6'h17,
        OP_BLT       = 6'h18,
        OP_BGE       = 6'h19,
        OP_BLTU      = 6'h1a,
        OP_BGEU      = 6'h1b
    } major_op_e;

    // inst[25:22] inside group 0
    typedef enum logic [3:0] {
        SUB_3R    = 4'h0,
        SUB_SHIFT = 4'h1,
        SUB_SLTI  = 4'h8,
        SUB_SLTUI = 4'h9,
        SUB_ADDI  = 4'ha,
        SUB_ANDI  = 4'hd,
        SUB_ORI   = 4'he,
        SUB_XORI  = 4'hf
    } grp0_op_e;

    // inst[25:22] for loads and stores
    // bit 2 marks a store, bit 3 zero extension, bits 1:0 the size
    typedef enum logic [3:0] {
        LD_B  = 4'h0,
        LD_H  = 4'h1,
        LD_W  = 4'h2,
        ST_B  = 4'h4,
        ST_H  = 4'h5,
        ST_W  = 4'h6,
        LD_BU = 4'h8,
        LD_HU = 4'h9
    } mem_sub_e;

    // {inst[21:20], inst[19:15]} for register and shift forms
    typedef enum logic [6:0] {
        F_SLLI  = 7'h01,
        F_SRLI  = 7'h09,
        F_SRAI  = 7'h11,
        F_ADD   = 7'h20,
        F_SUB   = 7'h22,
        F_SLT   = 7'h24,
        F_SLTU  = 7'h25,
        F_NOR   = 7'h28,
        F_AND   = 7'h29,
        F_OR    = 7'h2a,
        F_XOR   = 7'h2b,
        F_SLL   = 7'h2e,
        F_SRL   = 7'h2f,
        F_SRA   = 7'h30,
        F_MUL   = 7'h38,
        F_MULH  = 7'h39,
        F_MULHU = 7'h3a,
        F_DIV   = 7'h40,
        F_MOD   = 7'h41,
        F_DIVU  = 7'h42,
        F_MODU  = 7'h43
    } funct_e;

    typedef enum logic [3:0] {
        ALU_NONE, ALU_ADD, ALU_LUI, ALU_OR, ALU_SUB, ALU_XOR, ALU_SRA,
        ALU_AND, ALU_SLL, ALU_SRL, ALU_SLTU, ALU_NOR, ALU_SLT
    } alu_op_e;

    typedef enum logic [3:0] {
        BR_NONE, BR_JIRL, BR_B, BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU
    } br_op_e;

    typedef enum logic [2:0] {
        MD_NONE, MD_MUL, MD_MULH, MD_MULHU, MD_DIV, MD_MOD, MD_DIVU, MD_MODU
    } md_op_e;

    typedef enum logic [2:0] {
        IMM_NONE, IMM_SI12, IMM_UI12, IMM_SI16S2, IMM_SI26S2, IMM_UI5, IMM_UI20
    } imm_fmt_e;

    typedef enum logic [1:0] {
        SRC_REG = 2'd0,
        SRC_IMM = 2'd1,
        SRC_PC  = 2'd2
    } src_sel_e;

    typedef enum logic [1:0] {
        MEM_BYTE = 2'd0,
        MEM_HALF = 2'd1,
        MEM_WORD = 2'd2
    } mem_size_e;

endpackage

// ==== logic/pipe_pkg.sv ====
package pipe_pkg;

    typedef struct packed {
        logic               is_mem;
        logic               is_store;
        // ld.bu and ld.hu
        logic               zero_ext;
        isa_pkg::mem_size_e size;
    } mem_op_t;

    // the instruction currently sitting in execute
    typedef struct packed {
        logic              valid;
        logic              is_load;
        isa_pkg::reg_idx_t rd;
    } ex_load_t;

    // bundle handed from decode to execute
    typedef struct packed {
        isa_pkg::word_t    pc;
        isa_pkg::inst_t    inst;
        logic              inst_valid;
        isa_pkg::alu_op_e  alu_op;
        isa_pkg::md_op_e   md_op;
        logic              is_signed_md;
        isa_pkg::br_op_e   br_op;
        mem_op_t           mem;
        isa_pkg::src_sel_e src1_sel;
        isa_pkg::src_sel_e src2_sel;
        isa_pkg::reg_idx_t rj_idx;
        isa_pkg::reg_idx_t rkd_idx;
        logic              wreg_en;
        isa_pkg::reg_idx_t wreg_idx;
        // raw register file data, operand muxing happens in execute
        isa_pkg::word_t    src1;
        isa_pkg::word_t    src2;
        isa_pkg::word_t    imm;
    } id_ctrl_t;

    typedef enum logic {
        ST_EMPTY = 1'b0,
        ST_FULL  = 1'b1
    } stage_state_e;

endpackage

// ==== logic/inst_decoder.sv ====
`timescale 1ns/1ps

module inst_decoder (
    input  isa_pkg::inst_t     inst,
    output pipe_pkg::id_ctrl_t ctrl,
    output isa_pkg::imm_fmt_e  imm_fmt,
    output isa_pkg::reg_idx_t  reg_index1,
    output isa_pkg::reg_idx_t  reg_index2
);
    import isa_pkg::*;
    import pipe_pkg::*;

    logic [5:0] op_31_26;
    logic [3:0] op_25_22;
    logic [6:0] funct;
    reg_idx_t   rd;
    reg_idx_t   rj;
    reg_idx_t   rk;

    logic       valid;
    logic       is_bl;
    logic       is_cond_br;
    logic       wreg_en;
    alu_op_e    alu_op;
    br_op_e     br_op;
    md_op_e     md_op;
    mem_op_t    mem;
    src_sel_e   src1_sel;
    src_sel_e   src2_sel;

    assign op_31_26 = inst[31:26];
    assign op_25_22 = inst[25:22];
    assign funct    = inst[21:15];
    assign rd       = inst[4:0];
    assign rj       = inst[9:5];
    assign rk       = inst[14:10];

    always_comb begin
        valid   = 1'b0;
        is_bl   = 1'b0;
        alu_op  = ALU_NONE;
        br_op   = BR_NONE;
        md_op   = MD_NONE;
        mem     = '0;
        imm_fmt = IMM_NONE;
        case (op_31_26)
            OP_GRP0: begin
                case (op_25_22)
                    SUB_3R: begin
                        valid = 1'b1;
                        case (funct)
                            F_ADD:   alu_op = ALU_ADD;
                            F_SUB:   alu_op = ALU_SUB;
                            F_SLT:   alu_op = ALU_SLT;
                            F_SLTU:  alu_op = ALU_SLTU;
                            F_NOR:   alu_op = ALU_NOR;
                            F_AND:   alu_op = ALU_AND;
                            F_OR:    alu_op = ALU_OR;
                            F_XOR:   alu_op = ALU_XOR;
                            F_SLL:   alu_op = ALU_SLL;
                            F_SRL:   alu_op = ALU_SRL;
                            F_SRA:   alu_op = ALU_SRA;
                            F_MUL:   md_op = MD_MUL;
                            F_MULH:  md_op = MD_MULH;
                            F_MULHU: md_op = MD_MULHU;
                            F_DIV:   md_op = MD_DIV;
                            F_MOD:   md_op = MD_MOD;
                            F_DIVU:  md_op = MD_DIVU;
                            F_MODU:  md_op = MD_MODU;
                            default: valid = 1'b0;
                        endcase
                    end
                    SUB_SHIFT: begin
                        valid   = 1'b1;
                        imm_fmt = IMM_UI5;
                        case (funct)
                            F_SLLI: alu_op = ALU_SLL;
                            F_SRLI: alu_op = ALU_SRL;
                            F_SRAI: alu_op = ALU_SRA;
                            default: begin
                                valid   = 1'b0;
                                imm_fmt = IMM_NONE;
                            end
                        endcase
                    end
                    SUB_SLTI, SUB_SLTUI, SUB_ADDI: begin
                        valid   = 1'b1;
                        imm_fmt = IMM_SI12;
                        case (op_25_22)
                            SUB_SLTI:  alu_op = ALU_SLT;
                            SUB_SLTUI: alu_op = ALU_SLTU;
                            default:   alu_op = ALU_ADD;
                        endcase
                    end
                    // logical immediates are zero extended
                    SUB_ANDI, SUB_ORI, SUB_XORI: begin
                        valid   = 1'b1;
                        imm_fmt = IMM_UI12;
                        case (op_25_22)
                            SUB_ANDI: alu_op = ALU_AND;
                            SUB_ORI:  alu_op = ALU_OR;
                            default:  alu_op = ALU_XOR;
                        endcase
                    end
                    default: ;
                endcase
            end
            OP_LU12I: begin
                valid   = !inst[25];
                alu_op  = inst[25] ? ALU_NONE : ALU_LUI;
                imm_fmt = inst[25] ? IMM_NONE : IMM_UI20;
            end
            OP_PCADDU12I: begin
                valid   = !inst[25];
                alu_op  = inst[25] ? ALU_NONE : ALU_ADD;
                imm_fmt = inst[25] ? IMM_NONE : IMM_UI20;
            end
            OP_MEM: begin
                case (op_25_22)
                    LD_B, LD_H, LD_W, ST_B, ST_H, ST_W, LD_BU, LD_HU: begin
                        valid        = 1'b1;
                        alu_op       = ALU_ADD;
                        imm_fmt      = IMM_SI12;
                        mem.is_mem   = 1'b1;
                        mem.is_store = op_25_22[2];
                        mem.zero_ext = op_25_22[3];
                        mem.size     = mem_size_e'(op_25_22[1:0]);
                    end
                    default: ;
                endcase
            end
            OP_JIRL: begin
                valid   = 1'b1;
                alu_op  = ALU_ADD;
                br_op   = BR_JIRL;
                imm_fmt = IMM_SI16S2;
            end
            OP_B, OP_BL: begin
                valid   = 1'b1;
                is_bl   = inst[26];
                alu_op  = ALU_ADD;
                br_op   = BR_B;
                imm_fmt = IMM_SI26S2;
            end
            OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU: begin
                valid   = 1'b1;
                alu_op  = ALU_ADD;
                imm_fmt = IMM_SI16S2;
                case (op_31_26)
                    OP_BEQ:  br_op = BR_BEQ;
                    OP_BNE:  br_op = BR_BNE;
                    OP_BLT:  br_op = BR_BLT;
                    OP_BGE:  br_op = BR_BGE;
                    OP_BLTU: br_op = BR_BLTU;
                    default: br_op = BR_BGEU;
                endcase
            end
            default: ;
        endcase
    end

    // operand sources follow from the immediate format and branch kind
    always_comb begin
        src1_sel = SRC_REG;
        src2_sel = SRC_REG;
        case (imm_fmt)
            IMM_UI20: begin
                src1_sel = SRC_IMM;
                src2_sel = (alu_op == ALU_ADD) ? SRC_PC : SRC_REG;
            end
            IMM_NONE: ;
            default:  src2_sel = SRC_IMM;
        endcase
        if (br_op != BR_NONE && br_op != BR_JIRL)
            src1_sel = SRC_PC;
    end

    assign is_cond_br = br_op inside {BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU};

    // b and conditional branches have no result, bl and jirl write the link
    assign wreg_en = valid && !mem.is_store && !(is_cond_br || (br_op == BR_B && !is_bl));

    // stores and conditional branches read rd as the second source
    assign reg_index1 = rj;
    assign reg_index2 = (mem.is_store || is_cond_br) ? rd : rk;

    always_comb begin
        ctrl              = '0;
        ctrl.inst         = inst;
        ctrl.inst_valid   = valid;
        ctrl.alu_op       = alu_op;
        ctrl.md_op        = md_op;
        ctrl.is_signed_md = md_op inside {MD_MUL, MD_MULH, MD_DIV, MD_MOD};
        ctrl.br_op        = br_op;
        ctrl.mem          = mem;
        ctrl.src1_sel     = src1_sel;
        ctrl.src2_sel     = src2_sel;
        ctrl.rj_idx       = reg_index1;
        ctrl.rkd_idx      = reg_index2;
        ctrl.wreg_en      = wreg_en;
        ctrl.wreg_idx     = is_bl ? LINK_REG : rd;
    end

endmodule

// ==== logic/imm_gen.sv ====
`timescale 1ns/1ps

module imm_gen (
    input  isa_pkg::inst_t    inst,
    input  isa_pkg::imm_fmt_e imm_fmt,
    output isa_pkg::word_t    imm
);
    import isa_pkg::*;

    logic [11:0] i12;
    logic [15:0] i16;
    logic [25:0] i26;
    logic [19:0] i20;
    logic [4:0]  i5;

    assign i12 = inst[21:10];
    assign i16 = inst[25:10];
    // offs[25:16] sits in the low bits of the word
    assign i26 = {inst[9:0], inst[25:10]};
    assign i20 = inst[24:5];
    assign i5  = inst[14:10];

    always_comb begin
        case (imm_fmt)
            IMM_SI12:   imm = {{20{i12[11]}}, i12};
            IMM_UI12:   imm = {20'h0, i12};
            // branch offsets count words
            IMM_SI16S2: imm = {{14{i16[15]}}, i16, 2'b00};
            IMM_SI26S2: imm = {{4{i26[25]}}, i26, 2'b00};
            IMM_UI5:    imm = {27'h0, i5};
            IMM_UI20:   imm = {i20, 12'h0};
            default:    imm = '0;
        endcase
    end

endmodule

// ==== logic/stage_ctrl.sv ====
`timescale 1ns/1ps

module stage_ctrl (
    input  logic               clk,
    input  logic               arst_n,
    input  pipe_pkg::id_ctrl_t next_ctrl,
    input  logic               left_valid,
    output logic               left_ready,
    input  pipe_pkg::ex_load_t ex_load,
    input  logic               flush,
    output logic               right_valid,
    input  logic               right_ready,
    output pipe_pkg::id_ctrl_t id_out
);
    import pipe_pkg::*;

    stage_state_e state;
    stage_state_e state_nxt;
    logic         stall;
    logic         accept;

    // load in execute whose result is not ready for our operands yet
    assign stall = ex_load.valid && ex_load.is_load &&
                   (ex_load.rd == next_ctrl.rj_idx || ex_load.rd == next_ctrl.rkd_idx);

    // room when empty or when the held item leaves this cycle
    assign left_ready  = !stall && (state == ST_EMPTY || right_ready);
    assign accept      = left_valid && left_ready && !flush;
    assign right_valid = (state == ST_FULL);

    always_comb begin
        state_nxt = state;
        if (flush)
            state_nxt = ST_EMPTY;
        else if (accept)
            state_nxt = ST_FULL;
        else if (right_ready)
            state_nxt = ST_EMPTY;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state  <= ST_EMPTY;
            id_out <= '0;
        end else begin
            state <= state_nxt;
            // held otherwise, also under back-pressure
            if (accept)
                id_out <= next_ctrl;
        end
    end

endmodule

// ==== logic/id_stage_top.sv ====
`timescale 1ns/1ps

module id_stage_top (
    input  logic               clk,
    input  logic               arst_n,
    input  isa_pkg::inst_t     inst,
    input  isa_pkg::word_t     pc,
    input  logic               left_valid,
    output logic               left_ready,
    output isa_pkg::reg_idx_t  reg_index1,
    output isa_pkg::reg_idx_t  reg_index2,
    input  isa_pkg::word_t     reg_data1,
    input  isa_pkg::word_t     reg_data2,
    input  pipe_pkg::ex_load_t ex_load,
    input  logic               flush,
    output logic               right_valid,
    input  logic               right_ready,
    output pipe_pkg::id_ctrl_t id_out
);
    import isa_pkg::*;
    import pipe_pkg::*;

    id_ctrl_t dec_ctrl;
    id_ctrl_t next_ctrl;
    imm_fmt_e imm_fmt;
    word_t    imm;

    inst_decoder i_decoder (
        .inst       (inst),
        .ctrl       (dec_ctrl),
        .imm_fmt    (imm_fmt),
        .reg_index1 (reg_index1),
        .reg_index2 (reg_index2)
    );

    imm_gen i_imm_gen (
        .inst    (inst),
        .imm_fmt (imm_fmt),
        .imm     (imm)
    );

    // fill in the data fields the decoder leaves at zero
    always_comb begin
        next_ctrl      = dec_ctrl;
        next_ctrl.pc   = pc;
        next_ctrl.src1 = reg_data1;
        next_ctrl.src2 = reg_data2;
        next_ctrl.imm  = imm;
    end

    stage_ctrl i_stage_ctrl (
        .clk         (clk),
        .arst_n      (arst_n),
        .next_ctrl   (next_ctrl),
        .left_valid  (left_valid),
        .left_ready  (left_ready),
        .ex_load     (ex_load),
        .flush       (flush),
        .right_valid (right_valid),
        .right_ready (right_ready),
        .id_out      (id_out)
    );

endmodule

// ==== test/id_stage_asserts.sv ====
`timescale 1ns/1ps

module id_stage_asserts (
    input logic               clk,
    input logic               arst_n,
    input logic               flush,
    input logic               right_valid,
    input logic               right_ready,
    input pipe_pkg::id_ctrl_t id_out
);

    // item held by execute must not move
    property p_hold_stable;
        @(posedge clk) disable iff (!arst_n)
        (right_valid && !right_ready && !flush) |=> (right_valid && $stable(id_out));
    endproperty

    property p_flush_empties;
        @(posedge clk) disable iff (!arst_n)
        flush |=> !right_valid;
    endproperty

    a_hold_stable: assert property (p_hold_stable)
        else $error("id_out changed while execute held it back");

    a_flush_empties: assert property (p_flush_empties)
        else $error("right_valid high after a flush");

    a_reset_idle: assert property (@(posedge clk) !arst_n |-> !right_valid)
        else $error("right_valid high during reset");

endmodule

bind stage_ctrl id_stage_asserts i_asserts (
    .clk         (clk),
    .arst_n      (arst_n),
    .flush       (flush),
    .right_valid (right_valid),
    .right_ready (right_ready),
    .id_out      (id_out)
);

// ==== test/tb_vectors.svh ====
// one entry per instruction offered to the stage
// stimulus: inst, pc, ex_load, right_ready after accept, flush while full
// expected: inst_valid, alu_op, md_op, is_signed_md, br_op, mem, src1_sel, src2_sel,
//           rkd_idx, wreg_en, wreg_idx, imm

typedef struct packed {
    inst_t     inst;
    word_t     pc;
    ex_load_t  ex_load;
    logic      right_ready;
    logic      flush;
    logic      inst_valid;
    alu_op_e   alu_op;
    md_op_e    md_op;
    logic      is_signed_md;
    br_op_e    br_op;
    mem_op_t   mem;
    src_sel_e  src1_sel;
    src_sel_e  src2_sel;
    reg_idx_t  rkd_idx;
    logic      wreg_en;
    reg_idx_t  wreg_idx;
    word_t     imm;
} vec_t;

localparam int       NUM_VECTORS = 18;
localparam ex_load_t NO_LOAD     = '0;
// load in execute writing r20
localparam ex_load_t STALL_R20   = '{1'b1, 1'b1, 5'd20};
localparam mem_op_t  NO_MEM      = '0;
localparam mem_op_t  MEM_LD_BU   = '{1'b1, 1'b0, 1'b1, MEM_BYTE};
localparam mem_op_t  MEM_LD_H    = '{1'b1, 1'b0, 1'b0, MEM_HALF};
localparam mem_op_t  MEM_ST_W    = '{1'b1, 1'b1, 1'b0, MEM_WORD};

vec_t vectors [NUM_VECTORS] = '{
    // add.w, sub.w, slli.w, addi.w -8, ori 0x8a5, lu12i.w
    '{32'h001018a4, 32'h1c000000, NO_LOAD, 1'b1, 1'b0, 1'b1, ALU_ADD, MD_NONE, 1'b0,
      BR_NONE, NO_MEM, SRC_REG, SRC_REG, 5'd6, 1'b1, 5'd4, 32'h00000000},
    '{32'h00112507, 32'h1c000004, NO_LOAD, 1'b1, 1'b0, 1'b1, ALU_SUB, MD_NONE, 1'b0,
      BR_NONE, NO_MEM, SRC_REG, SRC_REG, 5'd9, 1'b1, 5'd7, 32'h00000000},
    '{32'h00408d6a, 32'h1c000008, NO_LOAD, 1'b1, 1'b0, 1'b1, ALU_SLL, MD_NONE, 1'b0,
      BR_NONE, NO_MEM, SRC_REG, SRC_IMM, 5'd3, 1'b1, 5'd10, 32'h00000003},
    '{32'h02bfe1ac, 32'h1c00000c, NO_LOAD, 1'b1, 1'b0, 1'b1, ALU_ADD, MD_NONE, 1'b0,
      BR_NONE, NO_MEM, SRC_REG, SRC_IMM, 5'd24, 1'b1, 5'd12, 32'hfffffff8},
    '{32'h03a295ee, 32'h1c000010, NO_LOAD, 1'b1, 1'b0, 1'b1, ALU_OR, MD_NONE, 1'b0,
      BR_NONE, NO_MEM, SRC_REG, SRC_IMM, 5'd5, 1'b1, 5'd14, 32'h000008a5},
    '{32'h15579bd0, 32'h1c000014, NO_LOAD, 1'b1, 1'b0, 1'b1, ALU_LUI, MD_NONE, 1'b0,
      BR_NONE, NO_MEM, SRC_IMM, SRC_REG, 5'd6, 1'b1, 5'd16, 32'habcde000},
    // ld.bu, ld.h behind a load-use stall on r20, st.w
    '{32'h2a004251, 32'h1c000018, NO_LOAD, 1'b1, 1'b0, 1'b1, ALU_ADD, MD_NONE, 1'b0,
      BR_NONE, MEM_LD_BU, SRC_REG, SRC_IMM, 5'd16, 1'b1, 5'd17, 32'h00000010},
    '{32'h287ffa93, 32'h1c00001c, STALL_R20, 1'b1, 1'b0, 1'b1, ALU_ADD, MD_NONE, 1'b0,
      BR_NONE, MEM_LD_H, SRC_REG, SRC_IMM, 5'd30, 1'b1, 5'd19, 32'hfffffffe},
    '{32'h298082d5, 32'h1c000020, NO_LOAD, 1'b1, 1'b0, 1'b1, ALU_ADD, MD_NONE, 1'b0,
      BR_NONE, MEM_ST_W, SRC_REG, SRC_IMM, 5'd21, 1'b0, 5'd21, 32'h00000020},
    // beq -16, bne +8 held by back-pressure, bl +0x1000, jirl r5
    '{32'h5bfff2f8, 32'h1c000024, NO_LOAD, 1'b1, 1'b0, 1'b1, ALU_ADD, MD_NONE, 1'b0,
      BR_BEQ, NO_MEM, SRC_PC, SRC_IMM, 5'd24, 1'b0, 5'd24, 32'hfffffff0},
    '{32'h5c000b3a, 32'h1c000028, NO_LOAD, 1'b0, 1'b0, 1'b1, ALU_ADD, MD_NONE, 1'b0,
      BR_BNE, NO_MEM, SRC_PC, SRC_IMM, 5'd26, 1'b0, 5'd26, 32'h00000008},
    '{32'h54100000, 32'h1c00002c, NO_LOAD, 1'b1, 1'b0, 1'b1, ALU_ADD, MD_NONE, 1'b0,
      BR_B, NO_MEM, SRC_PC, SRC_IMM, 5'd0, 1'b1, 5'd1, 32'h00001000},
    '{32'h4c000f65, 32'h1c000030, NO_LOAD, 1'b1, 1'b0, 1'b1, ALU_ADD, MD_NONE, 1'b0,
      BR_JIRL, NO_MEM, SRC_REG, SRC_IMM, 5'd3, 1'b1, 5'd5, 32'h0000000c},
    // mul.w, mulh.wu, div.w killed by flush, mod.wu, unknown word
    '{32'h001c1062, 32'h1c000034, NO_LOAD, 1'b1, 1'b0, 1'b1, ALU_NONE, MD_MUL, 1'b1,
      BR_NONE, NO_MEM, SRC_REG, SRC_REG, 5'd4, 1'b1, 5'd2, 32'h00000000},
    '{32'h001d20e6, 32'h1c000038, NO_LOAD, 1'b1, 1'b0, 1'b1, ALU_NONE, MD_MULHU, 1'b0,
      BR_NONE, NO_MEM, SRC_REG, SRC_REG, 5'd8, 1'b1, 5'd6, 32'h00000000},
    '{32'h00202d49, 32'h1c00003c, NO_LOAD, 1'b0, 1'b1, 1'b1, ALU_NONE, MD_DIV, 1'b1,
      BR_NONE, NO_MEM, SRC_REG, SRC_REG, 5'd11, 1'b1, 5'd9, 32'h00000000},
    '{32'h0021b9ac, 32'h1c000040, NO_LOAD, 1'b1, 1'b0, 1'b1, ALU_NONE, MD_MODU, 1'b0,
      BR_NONE, NO_MEM, SRC_REG, SRC_REG, 5'd14, 1'b1, 5'd12, 32'h00000000},
    '{32'hffffffff, 32'h1c000044, NO_LOAD, 1'b1, 1'b0, 1'b0, ALU_NONE, MD_NONE, 1'b0,
      BR_NONE, NO_MEM, SRC_REG, SRC_REG, 5'd31, 1'b0, 5'd31, 32'h00000000}
};

// ==== test/tb_top.sv ====
`timescale 1ns/1ps

module tb_top;
    import isa_pkg::*;
    import pipe_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 10;
    localparam int HOLD_CYCLES  = 3;
    localparam int ACCEPT_LIMIT = 8;

    `include "tb_vectors.svh"

    logic     clk;
    logic     arst_n;
    inst_t    inst;
    word_t    pc;
    logic     left_valid;
    logic     left_ready;
    reg_idx_t reg_index1;
    reg_idx_t reg_index2;
    word_t    reg_data1;
    word_t    reg_data2;
    ex_load_t ex_load;
    logic     flush;
    logic     right_valid;
    logic     right_ready;
    id_ctrl_t id_out;

    integer   seed;
    int       mismatch_count;
    int       failure_count;

    id_stage_top i_dut (
        .clk         (clk),
        .arst_n      (arst_n),
        .inst        (inst),
        .pc          (pc),
        .left_valid  (left_valid),
        .left_ready  (left_ready),
        .reg_index1  (reg_index1),
        .reg_index2  (reg_index2),
        .reg_data1   (reg_data1),
        .reg_data2   (reg_data2),
        .ex_load     (ex_load),
        .flush       (flush),
        .right_valid (right_valid),
        .right_ready (right_ready),
        .id_out      (id_out)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // each vector needs well under 10 cycles
    initial begin
        #((NUM_VECTORS * 10 + RESET_CYCLES) * CLK_PERIOD);
        $display("timeout: run did not finish after %0d cycles", NUM_VECTORS * 10 + RESET_CYCLES);
        $display("SIMULATION FAILED");
        $finish;
    end

    task automatic check_ctrl(input string name, input id_ctrl_t got, input id_ctrl_t exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("Mismatch at %0d ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("Mismatch at %0d ns: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_index(input string name, input reg_idx_t got, input reg_idx_t exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("Mismatch at %0d ns: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    // bundle as execute should see it
    function automatic id_ctrl_t expected_ctrl(input vec_t v, input word_t d1, input word_t d2);
        id_ctrl_t exp;
        exp              = '0;
        exp.pc           = v.pc;
        exp.inst         = v.inst;
        exp.inst_valid   = v.inst_valid;
        exp.alu_op       = v.alu_op;
        exp.md_op        = v.md_op;
        exp.is_signed_md = v.is_signed_md;
        exp.br_op        = v.br_op;
        exp.mem          = v.mem;
        exp.src1_sel     = v.src1_sel;
        exp.src2_sel     = v.src2_sel;
        exp.rj_idx       = v.inst[9:5];
        exp.rkd_idx      = v.rkd_idx;
        exp.wreg_en      = v.wreg_en;
        exp.wreg_idx     = v.wreg_idx;
        exp.src1         = d1;
        exp.src2         = d2;
        exp.imm          = v.imm;
        return exp;
    endfunction

    // returns at the edge that takes the item, or after the limit
    task automatic wait_accept(output bit ok);
        ok = 1'b0;
        for (int n = 0; n < ACCEPT_LIMIT && !ok; n++) begin
            #(CLK_PERIOD / 4);
            if (left_ready)
                ok = 1'b1;
            @(posedge clk);
        end
    endtask

    task automatic apply_vector(input vec_t v, input int idx);
        id_ctrl_t exp;
        bit       ok;
        string    name;
        name = $sformatf("id_out (vector %0d)", idx);
        @(negedge clk);
        inst        = v.inst;
        pc          = v.pc;
        reg_data1   = $random(seed);
        reg_data2   = $random(seed);
        ex_load     = v.ex_load;
        flush       = 1'b0;
        right_ready = 1'b1;
        left_valid  = 1'b1;
        exp = expected_ctrl(v, reg_data1, reg_data2);
        // load-use hazard keeps the item waiting
        if (v.ex_load.valid) begin
            repeat (2) begin
                #(CLK_PERIOD / 4);
                check_flag("left_ready", left_ready, 1'b0);
                @(negedge clk);
                check_flag("right_valid", right_valid, 1'b0);
            end
            ex_load = '0;
        end
        wait_accept(ok);
        @(negedge clk);
        left_valid = 1'b0;
        if (!ok) begin
            failure_count++;
            $display("vector %0d was never accepted by the DUT", idx);
            return;
        end
        // read ports still follow the word on the input
        check_index("reg_index1", reg_index1, v.inst[9:5]);
        check_index("reg_index2", reg_index2, v.rkd_idx);
        check_flag("right_valid", right_valid, 1'b1);
        check_ctrl(name, id_out, exp);
        right_ready = v.right_ready;
        if (!v.right_ready) begin
            repeat (HOLD_CYCLES) begin
                #(CLK_PERIOD / 4);
                check_flag("left_ready", left_ready, 1'b0);
                @(negedge clk);
                check_flag("right_valid", right_valid, 1'b1);
                check_ctrl(name, id_out, exp);
            end
        end
        if (v.flush) begin
            // the item offered alongside the flush is dropped
            flush       = 1'b1;
            left_valid  = 1'b1;
            right_ready = 1'b1;
            @(negedge clk);
            check_flag("right_valid", right_valid, 1'b0);
            flush      = 1'b0;
            left_valid = 1'b0;
        end else begin
            right_ready = 1'b1;
            @(negedge clk);
            check_flag("right_valid", right_valid, 1'b0);
        end
        right_ready = 1'b1;
    endtask

    initial begin
        seed           = 50950;
        mismatch_count = 0;
        failure_count  = 0;
        arst_n         = 1'b0;
        inst           = '0;
        pc             = '0;
        left_valid     = 1'b0;
        reg_data1      = '0;
        reg_data2      = '0;
        ex_load        = '0;
        flush          = 1'b0;
        right_ready    = 1'b1;
        repeat (RESET_CYCLES) @(negedge clk);
        check_flag("right_valid", right_valid, 1'b0);
        arst_n = 1'b1;
        #(CLK_PERIOD / 4);
        check_flag("left_ready", left_ready, 1'b1);
        check_ctrl("id_out", id_out, '0);
        for (int i = 0; i < NUM_VECTORS; i++)
            apply_vector(vectors[i], i);
        repeat (2) @(negedge clk);
        $display("result: %0d mismatches, %0d other errors", mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// ==== la_decode.f ====
+incdir+test
logic/isa_pkg.sv
logic/pipe_pkg.sv
logic/inst_decoder.sv
logic/imm_gen.sv
logic/stage_ctrl.sv
logic/id_stage_top.sv
test/id_stage_asserts.sv
test/tb_top.sv

// ==== run.sh ====
#!/bin/sh
# build and run the la_decode testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module tb_top -f la_decode.f
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/Vtb_top > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^SIMULATION PASSED$" sim.log; then
    exit 0
fi
echo "pass line not found in sim.log"
exit 1
